//--- hw/mipsPkg.sv
`default_nettype none

package mipsPkg;

	// width of a register number
	localparam int regAddrWidth = 5;

	////////////////////////////////////////////////////////////
	// primary opcodes
	localparam logic [5:0] opR     = 6'h00;
	localparam logic [5:0] opJ     = 6'h02;
	localparam logic [5:0] opBeq   = 6'h04;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw    = 6'h23;
	localparam logic [5:0] opSw    = 6'h2b;

	// funct field, R format only
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd  = 6'h24;
	localparam logic [5:0] fnOr   = 6'h25;
	localparam logic [5:0] fnSlt  = 6'h2a;

	////////////////////////////////////////////////////////////
	// register format
	typedef struct packed {
		logic [5:0]              op;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [regAddrWidth-1:0] rd;
		logic [4:0]              shamt;
		logic [5:0]              funct;
	} rFmtT;

	// immediate format, rs/rt/imm16 together form the J target
	typedef struct packed {
		logic [5:0]              op;
		logic [regAddrWidth-1:0] rs;
		logic [regAddrWidth-1:0] rt;
		logic [15:0]             imm16;
	} iFmtT;

	// one instruction word, two views
	typedef union packed {
		rFmtT rFmt;
		iFmtT iFmt;
	} instrWord;

endpackage

`default_nettype wire

//--- hw/corePkg.sv
`default_nettype none

package corePkg;

	////////////////////////////////////////////////////////////
	// alu operations
	localparam logic [2:0] aluAdd = 3'd0;
	localparam logic [2:0] aluSub = 3'd1;
	localparam logic [2:0] aluAnd = 3'd2;
	localparam logic [2:0] aluOr  = 3'd3;
	localparam logic [2:0] aluSlt = 3'd4;

	////////////////////////////////////////////////////////////
	// execute operand source
	// register file value from the ID/EX register
	localparam logic [1:0] fwdReg = 2'b00;
	// writeback result
	localparam logic [1:0] fwdWb  = 2'b01;
	// alu result sitting in memory stage
	localparam logic [1:0] fwdMem = 2'b10;

	// first fetch address
	localparam logic [31:0] resetPc = 32'h0000_0000;

endpackage

`default_nettype wire

//--- hw/controlDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecoder (
	input  wire mipsPkg::instrWord instrD,
	output logic                   regWrite,
	output logic                   memToReg,
	output logic                   memWrite,
	output logic                   aluSrc,
	output logic                   regDst,
	output logic                   branch,
	output logic                   jump,
	output logic [2:0]             aluOp
);
	import mipsPkg::*;
	import corePkg::*;

	always_comb begin
		// bubble unless recognised
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrc   = 1'b0;
		regDst   = 1'b0;
		branch   = 1'b0;
		jump     = 1'b0;
		aluOp    = aluAdd;
		case (instrD.iFmt.op)
			opR: begin
				// R format, funct picks the operation
				regDst   = 1'b1;
				regWrite = 1'b1;
				case (instrD.rFmt.funct)
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnSlt:  aluOp = aluSlt;
					// unsupported funct, no write
					default: regWrite = 1'b0;
				endcase
			end
			opAddiu: begin
				regWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			opLw: begin
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrc   = 1'b1;
			end
			// address is rs + imm, data from rt
			opSw: begin
				memWrite = 1'b1;
				aluSrc   = 1'b1;
			end
			opBeq: branch = 1'b1;
			opJ:   jump = 1'b1;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile (
	input  wire                              clk,
	input  wire                              arstN,
	input  wire                              writeEn,
	input  wire [mipsPkg::regAddrWidth-1:0]  readAddrA,
	input  wire [mipsPkg::regAddrWidth-1:0]  readAddrB,
	input  wire [mipsPkg::regAddrWidth-1:0]  writeAddr,
	input  wire [31:0]                       writeData,
	output logic [31:0]                      readDataA,
	output logic [31:0]                      readDataB
);
	import mipsPkg::*;

	logic [31:0] regs [2**regAddrWidth];

	// one read port: zero register, then write-through, then array
	function automatic logic [31:0] readPort(input logic [regAddrWidth-1:0] addr);
		if (addr == '0)
			return '0;
		if (writeEn && addr == writeAddr)
			return writeData;
		return regs[addr];
	endfunction

	// write on the edge, r0 never written
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			regs <= '{default: '0};
		else if (writeEn && writeAddr != '0)
			regs[writeAddr] <= writeData;
	end

	always_comb begin
		readDataA = readPort(readAddrA);
		readDataB = readPort(readAddrB);
	end

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  wire [31:0]  srcA,
	input  wire [31:0]  srcB,
	input  wire [2:0]   aluOp,
	output logic [31:0] result
);
	import corePkg::*;

	always_comb begin
		case (aluOp)
			// ADDU, ADDIU, load/store address
			aluAdd: result = srcA + srcB;
			aluSub: result = srcA - srcB;
			aluAnd: result = srcA & srcB;
			aluOr:  result = srcA | srcB;
			// signed compare, result is 0 or 1
			aluSlt: result = {31'b0, $signed(srcA) < $signed(srcB)};
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input  wire                              iStall,
	input  wire                              dStall,
	input  wire [mipsPkg::regAddrWidth-1:0]  rsD,
	input  wire [mipsPkg::regAddrWidth-1:0]  rtD,
	input  wire [mipsPkg::regAddrWidth-1:0]  rsE,
	input  wire [mipsPkg::regAddrWidth-1:0]  rtE,
	input  wire                              branchD,
	input  wire [mipsPkg::regAddrWidth-1:0]  writeRegE,
	input  wire [mipsPkg::regAddrWidth-1:0]  writeRegM,
	input  wire [mipsPkg::regAddrWidth-1:0]  writeRegW,
	input  wire                              regWriteE,
	input  wire                              regWriteM,
	input  wire                              regWriteW,
	input  wire                              memToRegE,
	input  wire                              memToRegM,
	output logic                             stallF,
	output logic                             stallD,
	output logic                             flushE,
	output logic                             forwardAD,
	output logic                             forwardBD,
	output logic [1:0]                       forwardAE,
	output logic [1:0]                       forwardBE,
	output logic                             longestStall
);
	import mipsPkg::*;
	import corePkg::*;

	logic loadUseStall;
	logic branchStall;

	// execute source, memory stage wins over writeback
	function automatic logic [1:0] fwdSel(input logic [regAddrWidth-1:0] src);
		if (src == '0)
			return fwdReg;
		if (regWriteM && src == writeRegM)
			return fwdMem;
		if (regWriteW && src == writeRegW)
			return fwdWb;
		return fwdReg;
	endfunction

	////////////////////////////////////////////////////////////
	// forwarding
	always_comb begin
		forwardAE = fwdSel(rsE);
		forwardBE = fwdSel(rtE);
	end

	// branch compare in decode, alu result from memory stage
	// writeback is covered by the register file write-through
	assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
	assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

	////////////////////////////////////////////////////////////
	// stalls
	// load in execute feeding decode
	assign loadUseStall = memToRegE && regWriteE &&
		((writeRegE == rsD) || (writeRegE == rtD));

	// branch operand still in flight
	assign branchStall = branchD &&
		((regWriteE && ((writeRegE == rsD) || (writeRegE == rtD))) ||
		(memToRegM && regWriteM && ((writeRegM == rsD) || (writeRegM == rtD))));

	assign stallF = loadUseStall || branchStall;
	assign stallD = loadUseStall || branchStall;
	// bubble into execute while decode waits
	assign flushE = loadUseStall || branchStall;

	// either memory busy freezes everything
	assign longestStall = iStall || dStall;

endmodule

`default_nettype wire

//--- hw/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input  wire                              clk,
	input  wire                              arstN,
	input  wire [31:0]                       instrF,
	input  wire [31:0]                       readDataM,
	// decoder
	input  wire                              regWriteD,
	input  wire                              memToRegD,
	input  wire                              memWriteD,
	input  wire                              aluSrcD,
	input  wire                              regDstD,
	input  wire                              branchD,
	input  wire                              jumpD,
	input  wire [2:0]                        aluOpD,
	// hazard unit
	input  wire                              stallF,
	input  wire                              stallD,
	input  wire                              flushE,
	input  wire                              forwardAD,
	input  wire                              forwardBD,
	input  wire [1:0]                        forwardAE,
	input  wire [1:0]                        forwardBE,
	input  wire                              longestStall,
	// memories
	output logic [31:0]                      pcF,
	output logic                             memWriteM,
	output logic [31:0]                      aluOutM,
	output logic [31:0]                      writeDataM,
	// stage state for decoder and hazard unit
	output mipsPkg::instrWord                instrD,
	output logic [mipsPkg::regAddrWidth-1:0] rsD,
	output logic [mipsPkg::regAddrWidth-1:0] rtD,
	output logic [mipsPkg::regAddrWidth-1:0] rsE,
	output logic [mipsPkg::regAddrWidth-1:0] rtE,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegE,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegM,
	output logic [mipsPkg::regAddrWidth-1:0] writeRegW,
	output logic                             regWriteE,
	output logic                             regWriteM,
	output logic                             regWriteW,
	output logic                             memToRegE,
	output logic                             memToRegM,
	// writeback debug
	output logic [31:0]                      debugWbPc,
	output logic [3:0]                       debugWbRfWen,
	output logic [4:0]                       debugWbRfWnum,
	output logic [31:0]                      debugWbRfWdata
);
	import mipsPkg::*;
	import corePkg::*;

	// fetch
	logic [31:0] pcPlus4F;
	logic [31:0] pcNextF;
	// decode
	logic [31:0] pcD;
	logic [31:0] pcPlus4D;
	logic [31:0] srcAD;
	logic [31:0] srcBD;
	logic [31:0] signImmD;
	logic [31:0] branchTargetD;
	logic [31:0] jumpTargetD;
	logic [regAddrWidth-1:0] rdD;
	logic takenD;
	// execute
	logic [31:0] pcE;
	logic [31:0] srcAE;
	logic [31:0] srcBE;
	logic [31:0] signImmE;
	logic [31:0] opAE;
	logic [31:0] opBE;
	logic [31:0] aluOutE;
	logic [regAddrWidth-1:0] rdE;
	logic regWriteRawE;
	logic memWriteE;
	logic aluSrcE;
	logic regDstE;
	logic [2:0] aluOpE;
	// memory, writeback
	logic [31:0] pcM;
	logic [31:0] pcW;
	logic [31:0] aluOutW;
	logic [31:0] readDataW;
	logic [31:0] resultW;
	logic memToRegW;
	logic wbWriteEn;

	// execute operand select
	function automatic logic [31:0] fwdMux(input logic [1:0] sel, input logic [31:0] regVal);
		case (sel)
			fwdMem:  return aluOutM;
			fwdWb:   return resultW;
			default: return regVal;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// fetch
	assign pcPlus4F = pcF + 32'd4;

	// redirect resolved in decode, delay slot already fetched
	always_comb begin
		if (jumpD)
			pcNextF = jumpTargetD;
		else if (takenD)
			pcNextF = branchTargetD;
		else
			pcNextF = pcPlus4F;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pcF <= resetPc;
		else if (!longestStall && !stallF)
			pcF <= pcNextF;
	end

	// IF/ID, all-zero word decodes to a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			instrD <= '0;
		else if (!longestStall && !stallD)
			instrD <= instrF;
	end

	always_ff @(posedge clk) begin
		if (!longestStall && !stallD)
			pcD <= pcF;
	end

	////////////////////////////////////////////////////////////
	// decode
	assign rsD = instrD.rFmt.rs;
	assign rtD = instrD.rFmt.rt;
	assign rdD = instrD.rFmt.rd;
	assign signImmD = {{16{instrD.iFmt.imm16[15]}}, instrD.iFmt.imm16};
	assign pcPlus4D = pcD + 32'd4;
	assign branchTargetD = pcPlus4D + {signImmD[29:0], 2'b00};
	// region of the delay slot, 26-bit word index
	assign jumpTargetD = {pcPlus4D[31:28], instrD.iFmt.rs, instrD.iFmt.rt,
		instrD.iFmt.imm16, 2'b00};

	regFile uRegFile (
		.clk       (clk),
		.arstN     (arstN),
		.writeEn   (wbWriteEn),
		.readAddrA (rsD),
		.readAddrB (rtD),
		.writeAddr (writeRegW),
		.writeData (resultW),
		.readDataA (srcAD),
		.readDataB (srcBD)
	);

	// equality on forwarded operands
	assign takenD = branchD &&
		((forwardAD ? aluOutM : srcAD) == (forwardBD ? aluOutM : srcBD));

	// ID/EX control, flush leaves a bubble
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteRawE <= 1'b0;
			memToRegE    <= 1'b0;
			memWriteE    <= 1'b0;
			aluSrcE      <= 1'b0;
			regDstE      <= 1'b0;
			aluOpE       <= aluAdd;
		end else if (!longestStall) begin
			regWriteRawE <= regWriteD && !flushE;
			memToRegE    <= memToRegD && !flushE;
			memWriteE    <= memWriteD && !flushE;
			aluSrcE      <= aluSrcD;
			regDstE      <= regDstD;
			aluOpE       <= aluOpD;
		end
	end

	always_ff @(posedge clk) begin
		if (!longestStall) begin
			pcE      <= pcD;
			srcAE    <= srcAD;
			srcBE    <= srcBD;
			signImmE <= signImmD;
			rsE      <= rsD;
			rtE      <= rtD;
			rdE      <= rdD;
		end
	end

	////////////////////////////////////////////////////////////
	// execute
	assign writeRegE = regDstE ? rdE : rtE;
	// r0 target never counts as a write
	assign regWriteE = regWriteRawE && (writeRegE != '0);
	assign opAE = fwdMux(forwardAE, srcAE);
	assign opBE = fwdMux(forwardBE, srcBE);

	alu uAlu (
		.srcA   (opAE),
		.srcB   (aluSrcE ? signImmE : opBE),
		.aluOp  (aluOpE),
		.result (aluOutE)
	);

	// EX/MEM
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
			memWriteM <= 1'b0;
		end else if (!longestStall) begin
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
			memWriteM <= memWriteE;
		end
	end

	always_ff @(posedge clk) begin
		if (!longestStall) begin
			aluOutM    <= aluOutE;
			writeDataM <= opBE;
			writeRegM  <= writeRegE;
			pcM        <= pcE;
		end
	end

	////////////////////////////////////////////////////////////
	// MEM/WB, load data taken in the access cycle
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			regWriteW <= 1'b0;
			memToRegW <= 1'b0;
		end else if (!longestStall) begin
			regWriteW <= regWriteM;
			memToRegW <= memToRegM;
		end
	end

	always_ff @(posedge clk) begin
		if (!longestStall) begin
			aluOutW   <= aluOutM;
			readDataW <= readDataM;
			writeRegW <= writeRegM;
			pcW       <= pcM;
		end
	end

	// writeback, one retirement per advancing cycle
	assign resultW = memToRegW ? readDataW : aluOutW;
	assign wbWriteEn = regWriteW && !longestStall;

	assign debugWbPc      = pcW;
	assign debugWbRfWen   = {4{wbWriteEn}};
	assign debugWbRfWnum  = writeRegW;
	assign debugWbRfWdata = resultW;

endmodule

`default_nettype wire

//--- hw/mipsCore.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCore (
	input  wire         clk,
	input  wire         arstN,
	input  wire [31:0]  instrF,
	input  wire [31:0]  readDataM,
	input  wire         iStall,
	input  wire         dStall,
	output logic [31:0] pcF,
	output logic        memWriteM,
	output logic [31:0] aluOutM,
	output logic [31:0] writeDataM,
	output logic        longestStall,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);
	import mipsPkg::*;

	// decode-stage controls
	instrWord instrD;
	logic regWriteD;
	logic memToRegD;
	logic memWriteD;
	logic aluSrcD;
	logic regDstD;
	logic branchD;
	logic jumpD;
	logic [2:0] aluOpD;

	// hazard selects
	logic stallF;
	logic stallD;
	logic flushE;
	logic forwardAD;
	logic forwardBD;
	logic [1:0] forwardAE;
	logic [1:0] forwardBE;

	// per-stage register numbers and enables
	logic [regAddrWidth-1:0] rsD;
	logic [regAddrWidth-1:0] rtD;
	logic [regAddrWidth-1:0] rsE;
	logic [regAddrWidth-1:0] rtE;
	logic [regAddrWidth-1:0] writeRegE;
	logic [regAddrWidth-1:0] writeRegM;
	logic [regAddrWidth-1:0] writeRegW;
	logic regWriteE;
	logic regWriteM;
	logic regWriteW;
	logic memToRegE;
	logic memToRegM;

	controlDecoder uDecoder (
		.instrD   (instrD),
		.regWrite (regWriteD),
		.memToReg (memToRegD),
		.memWrite (memWriteD),
		.aluSrc   (aluSrcD),
		.regDst   (regDstD),
		.branch   (branchD),
		.jump     (jumpD),
		.aluOp    (aluOpD)
	);

	// port names match the nets above
	datapath uDatapath (.*);

	hazardUnit uHazard (.*);

endmodule

`default_nettype wire

//--- testbench/mipsCore_sva.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreSva (
	input wire        clk,
	input wire        arstN,
	input wire        iStall,
	input wire        dStall,
	input wire        longestStall,
	input wire [31:0] pcF,
	input wire        memWriteM,
	input wire [3:0]  debugWbRfWen,
	input wire [4:0]  debugWbRfWnum
);

	// set by the first register write after reset
	logic seenRetire;

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			seenRetire <= 1'b0;
		else if (debugWbRfWen != 4'h0)
			seenRetire <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// stall rules
	stallIsOr: assert property (@(posedge clk) longestStall == (iStall || dStall))
		else $error("longestStall differs from iStall OR dStall");

	pcHeld: assert property (@(posedge clk) disable iff (!arstN)
		longestStall |=> $stable(pcF))
		else $error("pcF moved during a stall");

	// nothing retires while frozen
	noRetireInStall: assert property (@(posedge clk) longestStall |-> debugWbRfWen == 4'h0)
		else $error("register write retired during a stall");

	////////////////////////////////////////////////////////////
	// reset and writeback rules
	quietFromReset: assert property (@(posedge clk) !seenRetire |-> !memWriteM)
		else $error("store before the first retirement");

	noResetRetire: assert property (@(posedge clk) !arstN |-> debugWbRfWen == 4'h0)
		else $error("register write during reset");

	noZeroWrite: assert property (@(posedge clk) debugWbRfWen != 4'h0 |-> debugWbRfWnum != 5'd0)
		else $error("write to register 0 retired");

	wenReplicated: assert property (@(posedge clk) debugWbRfWen inside {4'h0, 4'hf})
		else $error("debugWbRfWen bits disagree");

endmodule

bind mipsCore mipsCoreSva uSva (
	.clk           (clk),
	.arstN         (arstN),
	.iStall        (iStall),
	.dStall        (dStall),
	.longestStall  (longestStall),
	.pcF           (pcF),
	.memWriteM     (memWriteM),
	.debugWbRfWen  (debugWbRfWen),
	.debugWbRfWnum (debugWbRfWnum)
);

`default_nettype wire

//--- testbench/mipsCoreTb.sv
`timescale 1ns/1ns
`default_nettype none

module mipsCoreTb;
	import mipsPkg::*;
	import corePkg::*;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 10;
	localparam int progWords = 27;
	// twice a rough seven cycles per instruction under random stalls
	localparam int watchdogCycles = 2 * (progWords * 7 + resetCycles);

	logic clk;
	logic arstN;
	logic iStall;
	logic dStall;
	logic [31:0] instrF;
	logic [31:0] readDataM;
	logic [31:0] pcF;
	logic memWriteM;
	logic [31:0] aluOutM;
	logic [31:0] writeDataM;
	logic longestStall;
	logic [31:0] debugWbPc;
	logic [3:0] debugWbRfWen;
	logic [4:0] debugWbRfWnum;
	logic [31:0] debugWbRfWdata;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	integer seed;
	int retired;

	// expected retirements in program order with delay slots
	logic [31:0] expPc [$];
	logic [4:0] expNum [$];
	logic [31:0] expData [$];
	logic [31:0] stAddr [$];
	logic [31:0] stData [$];

	mipsCore UUT (.*);

	////////////////////////////////////////////////////////////
	// encoders and helpers
	function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] funct);
		instrWord w;
		w.rFmt.op = opR;
		w.rFmt.rs = rs;
		w.rFmt.rt = rt;
		w.rFmt.rd = rd;
		w.rFmt.shamt = 5'd0;
		w.rFmt.funct = funct;
		return w;
	endfunction

	function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		instrWord w;
		w.iFmt.op = op;
		w.iFmt.rs = rs;
		w.iFmt.rt = rt;
		w.iFmt.imm16 = imm;
		return w;
	endfunction

	// target is a word index
	function automatic logic [31:0] encJ(input logic [25:0] target);
		instrWord w;
		w.iFmt.op = opJ;
		{w.iFmt.rs, w.iFmt.rt, w.iFmt.imm16} = target;
		return w;
	endfunction

	// initial ram word from the byte address
	function automatic logic [31:0] fillWord(input int k);
		return 32'hc0de_0000 | (k << 2);
	endfunction

	task automatic stopWithFail(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] want,
		input logic [31:0] got);
		assert (got === want) else
			stopWithFail($sformatf("error %s: expected %h, actual %h", name, want, got));
	endtask

	task automatic expectWrite(input logic [31:0] pc, input logic [4:0] num,
		input logic [31:0] data);
		expPc.push_back(pc);
		expNum.push_back(num);
		expData.push_back(data);
	endtask

	task automatic loadProgram();
		foreach (rom[k])
			rom[k] = 32'h0;
		rom[0]  = encI(opAddiu, 5'd0, 5'd1, 16'd5);
		// negative immediate
		rom[1]  = encI(opAddiu, 5'd0, 5'd2, 16'hfffd);
		// r2 from memory stage and r1 from writeback
		rom[2]  = encR(5'd1, 5'd2, 5'd3, fnAddu);
		rom[3]  = encR(5'd2, 5'd1, 5'd4, fnSubu);
		rom[4]  = encR(5'd4, 5'd1, 5'd5, fnSlt);
		rom[5]  = encR(5'd1, 5'd4, 5'd6, fnSlt);
		rom[6]  = encR(5'd1, 5'd2, 5'd7, fnAnd);
		rom[7]  = encR(5'd1, 5'd4, 5'd8, fnOr);
		// target r0 so nothing retires
		rom[8]  = encR(5'd1, 5'd1, 5'd0, fnAddu);
		rom[9]  = encI(opSw, 5'd0, 5'd3, 16'd8);
		rom[10] = encI(opLw, 5'd0, 5'd9, 16'd8);
		// load-use
		rom[11] = encR(5'd9, 5'd1, 5'd10, fnAddu);
		rom[12] = encI(opLw, 5'd0, 5'd11, 16'd8);
		// taken only once the loaded r11 matches r3
		rom[13] = encI(opBeq, 5'd11, 5'd3, 16'd2);
		rom[14] = encI(opAddiu, 5'd0, 5'd12, 16'd1);
		rom[15] = encI(opAddiu, 5'd0, 5'd13, 16'd99);
		rom[16] = encI(opAddiu, 5'd10, 5'd14, 16'd1);
		// not taken with the operand in execute
		rom[17] = encI(opBeq, 5'd14, 5'd0, 16'd3);
		rom[18] = encI(opAddiu, 5'd0, 5'd15, 16'd2);
		rom[19] = encI(opAddiu, 5'd0, 5'd16, 16'd3);
		rom[20] = encJ(26'd24);
		rom[21] = encI(opAddiu, 5'd0, 5'd17, 16'd4);
		rom[22] = encI(opAddiu, 5'd0, 5'd18, 16'd77);
		rom[23] = encI(opAddiu, 5'd0, 5'd19, 16'd88);
		rom[24] = encI(opSw, 5'd0, 5'd8, 16'd16);
		rom[25] = encR(5'd5, 5'd12, 5'd20, fnAddu);
		// park here with a nop delay slot
		rom[26] = encJ(26'd26);
	endtask

	task automatic loadExpected();
		expectWrite(32'd0, 5'd1, 32'd5);
		expectWrite(32'd4, 5'd2, 32'hffff_fffd);
		expectWrite(32'd8, 5'd3, 32'd2);
		expectWrite(32'd12, 5'd4, 32'hffff_fff8);
		expectWrite(32'd16, 5'd5, 32'd1);
		expectWrite(32'd20, 5'd6, 32'd0);
		expectWrite(32'd24, 5'd7, 32'd5);
		expectWrite(32'd28, 5'd8, 32'hffff_fffd);
		expectWrite(32'd40, 5'd9, 32'd2);
		expectWrite(32'd44, 5'd10, 32'd7);
		expectWrite(32'd48, 5'd11, 32'd2);
		expectWrite(32'd56, 5'd12, 32'd1);
		expectWrite(32'd64, 5'd14, 32'd8);
		expectWrite(32'd72, 5'd15, 32'd2);
		expectWrite(32'd76, 5'd16, 32'd3);
		expectWrite(32'd84, 5'd17, 32'd4);
		expectWrite(32'd100, 5'd20, 32'd2);
		stAddr.push_back(32'd8);
		stData.push_back(32'd2);
		stAddr.push_back(32'd16);
		stData.push_back(32'hffff_fffd);
	endtask

	////////////////////////////////////////////////////////////
	// clock and memories
	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// combinational reads with junk while busy
	assign instrF = iStall ? 32'hffff_ffff : rom[pcF[7:2]];
	assign readDataM = dStall ? 32'hbad0_bad0 : ram[aluOutM[7:2]];

	always @(posedge clk) begin
		if (memWriteM && !longestStall)
			ram[aluOutM[7:2]] <= writeDataM;
	end

	// random stalls once out of reset
	initial begin
		seed = 32'h2c4b_991c;
		@(posedge arstN);
		forever begin
			@(posedge clk);
			iStall <= ($random(seed) & 3) == 0;
			dStall <= ($random(seed) & 3) == 0;
		end
	end

	////////////////////////////////////////////////////////////
	// retirement and store checks at mid-cycle
	always @(negedge clk) begin
		logic [31:0] wantPc;
		logic [4:0] wantNum;
		logic [31:0] wantData;
		if (arstN && debugWbRfWen != 4'h0) begin
			assert (expNum.size() != 0) else
				stopWithFail("a register write retired after the expected list ended");
			wantPc = expPc.pop_front();
			wantNum = expNum.pop_front();
			wantData = expData.pop_front();
			checkValue($sformatf("retire %0d pc", retired), wantPc, debugWbPc);
			checkValue($sformatf("retire %0d reg", retired), {27'd0, wantNum},
				{27'd0, debugWbRfWnum});
			checkValue($sformatf("retire %0d data", retired), wantData, debugWbRfWdata);
			retired++;
		end
	end

	// one check per committed store
	always @(negedge clk) begin
		logic [31:0] wantAddr;
		logic [31:0] wantData;
		if (arstN && memWriteM && !longestStall) begin
			assert (stAddr.size() != 0) else
				stopWithFail("a store reached memory that the program does not make");
			wantAddr = stAddr.pop_front();
			wantData = stData.pop_front();
			checkValue("store address", wantAddr, aluOutM);
			checkValue("store data", wantData, writeDataM);
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge clk);
		stopWithFail($sformatf("watchdog expired after %0d cycles", watchdogCycles));
	end

	////////////////////////////////////////////////////////////
	// main sequence
	initial begin
		logic [31:0] want;
		arstN = 1'b0;
		iStall = 1'b0;
		dStall = 1'b0;
		retired = 0;
		loadProgram();
		foreach (ram[k])
			ram[k] = fillWord(k);
		loadExpected();
		repeat (resetCycles) @(posedge clk);
		arstN <= 1'b1;
		@(negedge clk);
		checkValue("reset pc", resetPc, pcF);
		while (expNum.size() != 0)
			@(negedge clk);
		@(negedge clk);
		assert (stAddr.size() == 0) else
			stopWithFail("not every expected store reached memory");
		// stored words changed and the rest keep the fill
		for (int k = 0; k < 64; k++) begin
			if (k == 2)
				want = 32'd2;
			else if (k == 4)
				want = 32'hffff_fffd;
			else
				want = fillWord(k);
			checkValue($sformatf("ram word %0d", k), want, ram[k]);
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- mipsCore.f
hw/mipsPkg.sv
hw/corePkg.sv
hw/controlDecoder.sv
hw/regFile.sv
hw/alu.sv
hw/hazardUnit.sv
hw/datapath.sv
hw/mipsCore.sv
testbench/mipsCore_sva.sv
testbench/mipsCoreTb.sv

//--- Makefile
# Verilator build and run of the mipsCore testbench
VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= mipsCore.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJDIR VFLAGS"

# a failing run exits nonzero through the simulator
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
